/* source/tcdm_pkg.sv */
// ----------------------------------------------------------------------
// Memory port widths and TCDM access kinds for the single-bank path
// Addresses are word addresses, one word is data_width bits wide
// The op travels on wen, where 1 means read
// ----------------------------------------------------------------------

package tcdm_pkg;

  // ----------------------------------------------------------------------
  // Port geometry
  // ----------------------------------------------------------------------
  localparam int unsigned addr_width = 8;                // Word address bits
  localparam int unsigned data_width = 32;               // Data word bits
  localparam int unsigned be_width   = data_width / 8;   // One enable per byte
  localparam int unsigned mem_words  = 2 ** addr_width;  // Full address space

  // ----------------------------------------------------------------------
  // Access kind, encoded as the wen level
  // ----------------------------------------------------------------------
  typedef enum logic {
    tcdm_write = 1'b0,  // wen low stores data
    tcdm_read  = 1'b1   // wen high fetches data
  } tcdm_op_e;

endpackage

/* source/ctrl_pkg.sv */
// ----------------------------------------------------------------------
// APB register map and access engine states
// Offsets are word indices on a 4-bit paddr, 7 and up are unmapped
// ----------------------------------------------------------------------

package ctrl_pkg;

  localparam int unsigned apb_addr_width = 4;  // Register index bits

  // ----------------------------------------------------------------------
  // Register offsets
  // ----------------------------------------------------------------------
  typedef enum logic [apb_addr_width-1:0] {
    reg_ctrl   = 4'h0,  // Enable and clear
    reg_addr   = 4'h1,  // Word address of the access
    reg_wdata  = 4'h2,  // Data for a write access
    reg_cmd    = 4'h3,  // Op bit, a write launches the access
    reg_status = 4'h4,  // Busy flag
    reg_rdata  = 4'h5,  // Last read data
    reg_count  = 4'h6   // Responses seen since last clear
  } reg_addr_e;

  localparam int unsigned ctrl_enable_bit = 0;  // Filter enable, sticky
  localparam int unsigned ctrl_clear_bit  = 1;  // Self-clearing pulse

  typedef enum logic [1:0] {
    idle,      // Waiting for GO
    request,   // req high on the port
    response   // r_valid slot
  } engine_state_e;

endpackage

/* source/tcdm_intf.sv */
// ----------------------------------------------------------------------
// TCDM request/response bundle with req/gnt and r_valid handshake
// A request moves when req and gnt are both high
// The response is expected exactly one cycle later
// ----------------------------------------------------------------------

`timescale 1ns/1ns

interface tcdm_intf
  import tcdm_pkg::*;
();

  // Request side, driven by the initiator
  logic                  req;
  logic [addr_width-1:0] add;
  tcdm_op_e              wen;   // 1 = read
  logic [be_width-1:0]   be;
  logic [data_width-1:0] data;

  // Grant and response, driven by the target
  logic                  gnt;
  logic                  r_valid;
  logic [data_width-1:0] r_data;

  modport initiator (
    output req, add, wen, be, data,
    input  gnt, r_valid, r_data
  );

  modport target (
    input  req, add, wen, be, data,
    output gnt, r_valid, r_data
  );

endinterface

/* source/tcdm_r_valid_filter.sv */
// ----------------------------------------------------------------------
// Drops write acknowledges from the response stream when enabled
// Only valid when r_valid follows gnt by exactly one cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tcdm_r_valid_filter
  import tcdm_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clear,
  input  logic            enable,
  tcdm_intf.target        tcdm_target,     // From the access engine
  tcdm_intf.initiator     tcdm_initiator   // Toward the memory
);

  tcdm_op_e op_q;  // Op of the last accepted request
  logic     accept;

  // ----------------------------------------------------------------------
  // Request path is a straight pass
  // ----------------------------------------------------------------------
  assign tcdm_initiator.req  = tcdm_target.req;
  assign tcdm_initiator.add  = tcdm_target.add;
  assign tcdm_initiator.wen  = tcdm_target.wen;
  assign tcdm_initiator.be   = tcdm_target.be;
  assign tcdm_initiator.data = tcdm_target.data;

  assign tcdm_target.gnt    = tcdm_initiator.gnt;
  assign tcdm_target.r_data = tcdm_initiator.r_data;

  // Handshake seen on the downstream port
  assign accept = tcdm_target.req & tcdm_initiator.gnt;

  // ----------------------------------------------------------------------
  // Response-valid masking
  // ----------------------------------------------------------------------
  assign tcdm_target.r_valid = enable ? (tcdm_initiator.r_valid & (op_q == tcdm_read))
                                      : tcdm_initiator.r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= tcdm_write;             // Nothing passes until a read goes out
    end else if (clear) begin
      op_q <= tcdm_write;
    end else if (enable && accept) begin
      op_q <= tcdm_target.wen;        // Tagged for next cycle's response
    end
  end

endmodule

/* source/tcdm_sram.sv */
// ----------------------------------------------------------------------
// Single-bank word memory, always granting
// Every access is answered one cycle after grant, reads with data,
// writes with zero data. Contents are undefined after power-up
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tcdm_sram
  import tcdm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  tcdm_intf.target tcdm
);

  logic [data_width-1:0] mem_q [mem_words];  // Storage array
  logic                  r_valid_q;
  logic [data_width-1:0] r_data_q;
  logic                  is_read;

  // No stalls, every request is granted in its own cycle
  assign tcdm.gnt = 1'b1;

  assign is_read = (tcdm.wen == tcdm_read);

  // ----------------------------------------------------------------------
  // Array write with byte enables
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (tcdm.req && !is_read) begin
      for (int i = 0; i < be_width; i++) begin
        if (tcdm.be[i]) begin
          mem_q[tcdm.add][i*8 +: 8] <= tcdm.data[i*8 +: 8];  // Lane i
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Response, one cycle after the grant
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= tcdm.req;  // Reads and writes alike
    end
  end

  always_ff @(posedge clk_i) begin
    if (tcdm.req) begin
      r_data_q <= is_read ? mem_q[tcdm.add] : '0;  // Zero after a write
    end
  end

  assign tcdm.r_valid = r_valid_q;
  assign tcdm.r_data  = r_data_q;

endmodule

/* source/tcdm_access_engine.sv */
// ----------------------------------------------------------------------
// Single-shot TCDM initiator driven by the register file
// One request per GO, all byte enables set. go must only arrive idle
// The response slot is fixed at one cycle after grant
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tcdm_access_engine
  import tcdm_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  go,
  input  tcdm_op_e              op,
  input  logic [addr_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic                  count_clear,
  output logic                  busy,
  output logic [data_width-1:0] count,
  output logic [data_width-1:0] rdata,
  tcdm_intf.initiator           tcdm
);

  engine_state_e         state_q, state_d;
  tcdm_op_e              op_q;        // Op of the access in flight
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q;
  logic [data_width-1:0] count_q;
  logic [data_width-1:0] rdata_q;
  logic                  resp_seen;

  // ----------------------------------------------------------------------
  // FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle:     if (go) state_d = request;
      request:  if (tcdm.gnt) state_d = response;  // Granted at once
      response: state_d = idle;                    // Slot passes with or without r_valid
      default:  state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Access fields, captured with GO
  always_ff @(posedge clk_i) begin
    if (go && state_q == idle) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // ----------------------------------------------------------------------
  // Request drive
  // ----------------------------------------------------------------------
  assign tcdm.req  = (state_q == request);
  assign tcdm.add  = addr_q;
  assign tcdm.wen  = op_q;
  assign tcdm.be   = '1;        // Full words only
  assign tcdm.data = wdata_q;

  // ----------------------------------------------------------------------
  // Response collection
  // ----------------------------------------------------------------------
  assign resp_seen = (state_q == response) && tcdm.r_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (count_clear) begin
      count_q <= '0;              // Clear wins over a coincident response
    end else if (resp_seen) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (resp_seen && op_q == tcdm_read) begin
      rdata_q <= tcdm.r_data;     // Write acks leave it alone
    end
  end

  assign busy  = (state_q != idle);
  assign count = count_q;
  assign rdata = rdata_q;

endmodule

/* source/apb_ctrl_regs.sv */
// ----------------------------------------------------------------------
// APB slave for the access path, no wait states (pready tied high)
// paddr is a word index. Writes to read-only registers are ignored
// pslverr on unmapped offsets and on a command write while busy
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module apb_ctrl_regs
  import tcdm_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [data_width-1:0]     pwdata,
  output logic [data_width-1:0]     prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      enable,
  output logic                      clear,
  output logic                      go,
  output tcdm_op_e                  op,
  output logic [addr_width-1:0]     addr,
  output logic [data_width-1:0]     wdata,
  output logic                      count_clear,
  input  logic                      busy,
  input  logic [data_width-1:0]     count,
  input  logic [data_width-1:0]     rdata
);

  reg_addr_e             reg_sel;
  logic                  access;      // APB access phase
  logic                  wr_access;
  logic                  mapped;
  logic                  cmd_refused;
  logic                  enable_q;
  tcdm_op_e              cmd_op_q;    // Last op written, for readback
  logic [addr_width-1:0] addr_q;
  logic [data_width-1:0] wdata_q;
  logic [data_width-1:0] rdata_mux;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  assign reg_sel   = reg_addr_e'(paddr);
  assign access    = psel & penable;
  assign wr_access = access & pwrite;

  always_comb begin
    unique case (reg_sel)
      reg_ctrl, reg_addr, reg_wdata, reg_cmd,
      reg_status, reg_rdata, reg_count: mapped = 1'b1;
      default:                          mapped = 1'b0;
    endcase
  end

  assign cmd_refused = wr_access & (reg_sel == reg_cmd) & busy;

  assign pready  = 1'b1;
  assign pslverr = access & (~mapped | cmd_refused);

  // Pulses, both live for the single access cycle
  assign go    = wr_access & (reg_sel == reg_cmd) & ~busy;
  assign clear = wr_access & (reg_sel == reg_ctrl) & pwdata[ctrl_clear_bit];
  assign op    = tcdm_op_e'(pwdata[0]);  // Taken by the engine together with go

  assign count_clear = clear;            // Counter shares the filter clear

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      cmd_op_q <= tcdm_write;
    end else if (wr_access) begin
      if (reg_sel == reg_ctrl) enable_q <= pwdata[ctrl_enable_bit];
      if (go) cmd_op_q <= op;            // Refused command keeps the old op
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_access && reg_sel == reg_addr) begin
      addr_q <= pwdata[addr_width-1:0];
    end
    if (wr_access && reg_sel == reg_wdata) begin
      wdata_q <= pwdata;
    end
  end

  // ----------------------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------------------
  always_comb begin
    rdata_mux = '0;
    unique case (reg_sel)
      reg_ctrl:   rdata_mux[ctrl_enable_bit] = enable_q;  // Clear bit reads zero
      reg_addr:   rdata_mux = data_width'(addr_q);
      reg_wdata:  rdata_mux = wdata_q;
      reg_cmd:    rdata_mux[0] = cmd_op_q;
      reg_status: rdata_mux[0] = busy;
      reg_rdata:  rdata_mux = rdata;
      reg_count:  rdata_mux = count;
      default:    rdata_mux = '0;
    endcase
  end

  assign prdata = rdata_mux;
  assign enable = enable_q;
  assign addr   = addr_q;
  assign wdata  = wdata_q;

endmodule

/* source/tcdm_filter_top.sv */
// ----------------------------------------------------------------------
// APB-controlled TCDM access path with response-valid filter
// Single initiator, single bank, no ECC, no stalls
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tcdm_filter_top
  import tcdm_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [data_width-1:0]     pwdata,
  output logic [data_width-1:0]     prdata,
  output logic                      pready,
  output logic                      pslverr
);

  logic                  enable;
  logic                  clear;
  logic                  go;
  tcdm_op_e              op;
  logic [addr_width-1:0] addr;
  logic [data_width-1:0] wdata;
  logic                  count_clear;
  logic                  busy;
  logic [data_width-1:0] count;
  logic [data_width-1:0] rdata;

  tcdm_intf tcdm_eng ();  // Engine to filter
  tcdm_intf tcdm_mem ();  // Filter to memory

  apb_ctrl_regs u_regs (
    .clk_i, .rst_ni,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .enable, .clear, .go, .op, .addr, .wdata, .count_clear,
    .busy, .count, .rdata
  );

  tcdm_access_engine u_engine (
    .clk_i, .rst_ni,
    .go, .op, .addr, .wdata, .count_clear,
    .busy, .count, .rdata,
    .tcdm (tcdm_eng.initiator)
  );

  tcdm_r_valid_filter u_filter (
    .clk_i, .rst_ni,
    .clear, .enable,
    .tcdm_target    (tcdm_eng.target),
    .tcdm_initiator (tcdm_mem.initiator)
  );

  tcdm_sram u_sram (
    .clk_i, .rst_ni,
    .tcdm (tcdm_mem.target)
  );

endmodule

/* test/tb_tcdm_filter.sv */
// ----------------------------------------------------------------------
// Testbench for the APB-controlled TCDM access path
// Cases come from test/filter_cases.txt, run from the project root
// Ops are w (APB write), r (APB read), p (poll status until idle)
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module tb_tcdm_filter
  import tcdm_pkg::*;
  import ctrl_pkg::*;
();

  localparam int    drive_skew = 2;                      // ns after the rising edge
  localparam string case_path  = "test/filter_cases.txt";

  logic                      clk_i;
  logic                      rst_ni;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [apb_addr_width-1:0] paddr;
  logic [data_width-1:0]     pwdata;
  logic [data_width-1:0]     prdata;
  logic                      pready;
  logic                      pslverr;

  string                     case_name [$];
  string                     case_op   [$];
  logic [apb_addr_width-1:0] case_off  [$];
  logic [data_width-1:0]     case_data [$];  // pwdata for writes, expected prdata for reads
  logic                      case_err  [$];  // Expected pslverr

  int cycles = 0;
  int limit  = 0;   // Zero until the case count is known

  tcdm_filter_top dut_i (
    .clk_i, .rst_ni,
    .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;  // 10 ns period
  end

  // ----------------------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, the case list did not finish", cycles);
      $display("STATUS: FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(string name, logic [data_width-1:0] exp, logic [data_width-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "Data mismatch");
    end
  endtask

  task automatic check_err(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s expected pslverr %b actual %b", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "Error response mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // APB driver, entered and left at drive_skew after a rising edge
  // ----------------------------------------------------------------------
  task automatic apb_transfer(logic wr, logic [apb_addr_width-1:0] off,
                              logic [data_width-1:0] wdata,
                              output logic [data_width-1:0] rdata, output logic err);
    psel    = 1'b1;              // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = off;
    pwdata  = wdata;
    @(posedge clk_i);
    #drive_skew penable = 1'b1;  // Access phase
    @(negedge clk_i);            // Mid-cycle, outputs settled
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) begin
      $display("APB slave did not signal ready in the access phase at offset %h", off);
      $display("STATUS: FAIL");
      $fatal(1, "Protocol violation");
    end
    @(posedge clk_i);            // Transfer completes here
    #drive_skew;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_idle(string name);
    logic [data_width-1:0] status;
    logic                  err;
    do begin
      apb_transfer(1'b0, reg_status, '0, status, err);
      check_err(name, 1'b0, err);
    end while (status[0]);       // Busy bit, timeout guards the loop
  endtask

  task automatic run_case(int i);
    logic [data_width-1:0] rd;
    logic                  err;
    if (case_op[i] == "w") begin
      apb_transfer(1'b1, case_off[i], case_data[i], rd, err);
      check_err(case_name[i], case_err[i], err);
    end else if (case_op[i] == "r") begin
      apb_transfer(1'b0, case_off[i], '0, rd, err);
      check_err(case_name[i], case_err[i], err);
      check_data(case_name[i], case_data[i], rd);
    end else if (case_op[i] == "p") begin
      wait_idle(case_name[i]);
    end else begin
      $display("Case %s has an unknown operation %s", case_name[i], case_op[i]);
      $display("STATUS: FAIL");
      $fatal(1, "Bad case line");
    end
  endtask

  // ----------------------------------------------------------------------
  // Case file reader, lines starting with # are skipped
  // ----------------------------------------------------------------------
  task automatic load_cases();
    int                    fd;
    int                    n;
    string                 line;
    string                 name;
    string                 op;
    logic [31:0]           off;
    logic [data_width-1:0] data;
    int                    err;
    fd = $fopen(case_path, "r");
    if (fd == 0) begin
      $display("Cannot open the case file %s", case_path);
      $display("STATUS: FAIL");
      $fatal(1, "Missing stimulus");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %s %h %h %d", name, op, off, data, err);
          if (n == 5) begin
            case_name.push_back(name);
            case_op.push_back(op);
            case_off.push_back(off[apb_addr_width-1:0]);
            case_data.push_back(data);
            case_err.push_back(err != 0);
          end else begin
            $display("Malformed case line: %s", line);
            $display("STATUS: FAIL");
            $fatal(1, "Bad case file");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_ni  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    load_cases();
    limit = 20 * case_name.size() + 50;  // Polls finish well inside this
    repeat (3) @(posedge clk_i);
    #drive_skew rst_ni = 1'b1;           // Reset held for 3 cycles
    @(posedge clk_i);
    #drive_skew;
    foreach (case_name[i]) begin
      run_case(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* test/filter_cases.txt */
# name op offset(hex) data(hex) err
# op w writes data, r reads and expects data, p polls status until idle
rst_ctrl    r 0 00000000 0
rst_count   r 6 00000000 0
rst_status  r 4 00000000 0
rst_rdata   r 5 00000000 0
d_addr      w 1 00000010 0
d_wdata     w 2 cafe0001 0
d_go_wr     w 3 00000000 0
d_wait_wr   p 4 00000000 0
d_go_rd     w 3 00000001 0
d_wait_rd   p 4 00000000 0
d_rdata     r 5 cafe0001 0
d_count     r 6 00000002 0
e_enable    w 0 00000001 0
e_ctrl      r 0 00000001 0
e_addr      w 1 00000022 0
e_wdata     w 2 12345678 0
e_go_wr     w 3 00000000 0
e_wait_wr   p 4 00000000 0
e_count_wr  r 6 00000002 0
e_rdata_wr  r 5 cafe0001 0
e_go_rd     w 3 00000001 0
e_wait_rd   p 4 00000000 0
e_rdata_rd  r 5 12345678 0
e_count_rd  r 6 00000003 0
c_clear     w 0 00000003 0
c_ctrl      r 0 00000001 0
c_count     r 6 00000000 0
b_go_1      w 3 00000001 0
b_go_busy   w 3 00000001 1
b_wait      p 4 00000000 0
b_count     r 6 00000001 0
b_go_again  w 3 00000001 0
b_wait_2    p 4 00000000 0
b_count_2   r 6 00000002 0
b_rdata     r 5 12345678 0
u_rd_7      r 7 00000000 1
u_wr_9      w 9 ffffffff 1
u_rd_f      r f 00000000 1
u_count     r 6 00000002 0

/* sources.f */
source/tcdm_pkg.sv
source/ctrl_pkg.sv
source/tcdm_intf.sv
source/tcdm_r_valid_filter.sv
source/tcdm_sram.sv
source/tcdm_access_engine.sv
source/apb_ctrl_regs.sv
source/tcdm_filter_top.sv
test/tb_tcdm_filter.sv

/* Bender.yml */
package:
  name: tcdm_filter

sources:
  - target: any(rtl, test)
    files:
      - source/tcdm_pkg.sv
      - source/ctrl_pkg.sv
      - source/tcdm_intf.sv
      - source/tcdm_r_valid_filter.sv
      - source/tcdm_sram.sv
      - source/tcdm_access_engine.sv
      - source/apb_ctrl_regs.sv
      - source/tcdm_filter_top.sv
  - target: test
    files:
      - test/tb_tcdm_filter.sv
